// ==== flist.f ====
axi_bridge_pkg.sv
axi_wr_hold.sv
axi_wr_addr_gen.sv
axi_wr_resp.sv
axi_wr_ctrl.sv
axi_axil_wr_bridge.sv
axi_axil_wr_bridge_props.sv
axi_axil_wr_bridge_tb.sv

// ==== Makefile ====
TOP := axi_axil_wr_bridge_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// ==== axi_axil_wr_bridge_tb.sv ====
`timescale 1ns/1ns

module axi_axil_wr_bridge_tb;

  import axi_bridge_pkg::*;

  typedef struct packed {
    logic [AXI_ADDR_WIDTH-1:0] addr;
    logic [AXI_DATA_WIDTH-1:0] data;
    logic [AXI_STRB_WIDTH-1:0] strb;
  } lite_beat_t;

  logic       clk;
  logic       rst_n;
  axi_aw_t    s_axi_aw;
  logic       s_axi_awvalid;
  logic       s_axi_awready;
  axi_w_t     s_axi_w;
  logic       s_axi_wvalid;
  logic       s_axi_wready;
  axi_b_t     s_axi_b;
  logic       s_axi_bvalid;
  logic       s_axi_bready;
  axil_aw_t   m_axil_aw;
  logic       m_axil_awvalid;
  logic       m_axil_awready;
  axil_w_t    m_axil_w;
  logic       m_axil_wvalid;
  logic       m_axil_wready;
  logic [1:0] m_axil_bresp;
  logic       m_axil_bvalid;
  logic       m_axil_bready;

  logic [31:0] lcg_state;

  axi_axil_wr_bridge dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped after an error.");
  endtask

  task automatic check_eq(input logic [63:0] got, input logic [63:0] want, input string what);
    if (got !== want) begin
      abort_run($sformatf("[FAIL] %0t ns: %s: got 0x%0h, expected 0x%0h",
                          $time, what, got, want));
    end
  endtask

  task automatic run_burst(input int n);
    axi_aw_t     aw;
    axi_w_t      wb;
    lite_beat_t  beats[$];
    lite_beat_t  sent_beats[$];
    lite_beat_t  want_beat;
    lite_beat_t  got_beat;
    logic [31:0] r;
    logic [1:0]  want_resp;
    logic [1:0]  lite_resp;
    int          w_idx;
    int          lite_idx;
    int          b_wait;
    int          cycles;
    bit          aw_sent;
    bit          w_on;
    bit          have_aw;
    bit          have_w;
    bit          b_pending;
    bit          lite_b_on;
    bit          done;
    r = next_rand();
    aw.len   = {5'd0, r[31:29]};
    aw.size  = {2'b00, r[28]};
    aw.burst = (r[27:26] == 2'd3) ? BURST_INCR : r[27:26];  // Reserved code sent as INCR.
    aw.id    = r[25:22];
    aw.user  = r[21:20];
    r = next_rand();
    aw.addr  = {r[31:13], r[12] & ~aw.size[0]};              // Aligned to the beat size.
    for (int i = 0; i <= int'(aw.len); i++) begin
      r = next_rand();
      if (aw.burst == BURST_FIXED) begin
        want_beat.addr = aw.addr;
      end else begin
        want_beat.addr = aw.addr + AXI_ADDR_WIDTH'(i * (1 << aw.size));
      end
      want_beat.data = r[31:16];
      want_beat.strb = r[15:14];
      beats.push_back(want_beat);
    end
    sent_beats = beats;
    want_resp  = RESP_OKAY;
    lite_resp  = RESP_OKAY;
    got_beat   = '0;
    w_idx      = 0;
    lite_idx   = 0;
    b_wait     = 0;
    cycles     = 0;
    aw_sent    = 1'b0;
    w_on       = 1'b0;
    have_aw    = 1'b0;
    have_w     = 1'b0;
    b_pending  = 1'b0;
    lite_b_on  = 1'b0;
    done       = 1'b0;
    s_axi_aw      <= aw;
    s_axi_awvalid <= 1'b1;
    while (!done) begin
      @(posedge clk);
      cycles++;
      if (cycles > 4000) begin
        abort_run($sformatf("Timeout: burst %0d did not finish within 4000 cycles.", n));
      end
      if (s_axi_awvalid && s_axi_awready) begin
        aw_sent = 1'b1;
      end else if (aw_sent) begin
        check_eq(64'(s_axi_awready), 64'(0), "awready while a burst is open");
      end
      if (w_on && s_axi_wready) begin
        w_on = 1'b0;
        w_idx++;
      end
      if (m_axil_awvalid && m_axil_awready) begin
        check_eq(64'(have_aw), 64'(0), "second AXI-Lite address before its data");
        got_beat.addr = m_axil_aw.addr;
        have_aw = 1'b1;
      end
      if (m_axil_wvalid && m_axil_wready) begin
        check_eq(64'(have_w), 64'(0), "second AXI-Lite data before its address");
        got_beat.data = m_axil_w.data;
        got_beat.strb = m_axil_w.strb;
        have_w = 1'b1;
      end
      if (lite_b_on && m_axil_bready) begin
        lite_b_on = 1'b0;
      end
      if (have_aw && have_w) begin
        if (beats.size() == 0) begin
          abort_run($sformatf("Burst %0d produced more AXI-Lite writes than beats.", n));
        end
        want_beat = beats.pop_front();
        check_eq(64'(got_beat.addr), 64'(want_beat.addr),
                 $sformatf("burst %0d beat %0d address", n, lite_idx));
        check_eq(64'(got_beat.data), 64'(want_beat.data),
                 $sformatf("burst %0d beat %0d data", n, lite_idx));
        check_eq(64'(got_beat.strb), 64'(want_beat.strb),
                 $sformatf("burst %0d beat %0d strobe", n, lite_idx));
        have_aw = 1'b0;
        have_w  = 1'b0;
        lite_idx++;
        r = next_rand();
        lite_resp = r[31:30];
        b_wait    = int'(r[29:28]);
        b_pending = 1'b1;
        case (lite_resp)
          RESP_DECERR: begin
            want_resp = RESP_DECERR;
          end
          RESP_SLVERR: begin
            if (want_resp != RESP_DECERR) begin
              want_resp = RESP_SLVERR;                          // Worst code so far.
            end
          end
          default: begin
          end
        endcase
      end
      if (s_axi_bvalid && s_axi_bready) begin
        check_eq(64'(lite_idx), 64'(int'(aw.len) + 1), $sformatf("burst %0d beat count", n));
        check_eq(64'(s_axi_b.id), 64'(aw.id), $sformatf("burst %0d B id", n));
        check_eq(64'(s_axi_b.user), 64'(aw.user), $sformatf("burst %0d B user", n));
        check_eq(64'(s_axi_b.resp), 64'(want_resp), $sformatf("burst %0d B resp", n));
        done = 1'b1;
      end
      if (!w_on && w_idx <= int'(aw.len)) begin
        r = next_rand();
        if (r[31]) begin
          w_on    = 1'b1;
          wb.data = sent_beats[w_idx].data;
          wb.strb = sent_beats[w_idx].strb;
          wb.last = (w_idx == int'(aw.len));
          s_axi_w <= wb;
        end
      end
      if (b_pending) begin
        if (b_wait == 0) begin
          b_pending = 1'b0;
          lite_b_on = 1'b1;
          m_axil_bresp <= lite_resp;
        end else begin
          b_wait--;
        end
      end
      r = next_rand();
      s_axi_awvalid  <= !aw_sent;
      s_axi_wvalid   <= w_on;
      m_axil_bvalid  <= lite_b_on;
      m_axil_awready <= r[31] | r[30];                        // Ready about 3 of 4 cycles.
      m_axil_wready  <= r[29] | r[28];
      s_axi_bready   <= r[27];
    end
  endtask

  initial begin
    lcg_state = 32'd36;
    rst_n          <= 1'b0;
    s_axi_aw       <= '0;
    s_axi_awvalid  <= 1'b0;
    s_axi_w        <= '0;
    s_axi_wvalid   <= 1'b0;
    s_axi_bready   <= 1'b0;
    m_axil_awready <= 1'b0;
    m_axil_wready  <= 1'b0;
    m_axil_bresp   <= RESP_OKAY;
    m_axil_bvalid  <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_eq(64'(m_axil_awvalid), 64'(0), "m_axil_awvalid after reset");
    check_eq(64'(m_axil_wvalid), 64'(0), "m_axil_wvalid after reset");
    check_eq(64'(s_axi_bvalid), 64'(0), "s_axi_bvalid after reset");
    check_eq(64'(s_axi_awready), 64'(1), "s_axi_awready after reset");
    for (int n = 0; n < 200; n++) begin
      run_burst(n);
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== axi_axil_wr_bridge_props.sv ====
`timescale 1ns/1ns

module axi_axil_wr_bridge_props (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     s_axi_awvalid,
  input logic                     s_axi_awready,
  input axi_bridge_pkg::axi_b_t   s_axi_b,
  input logic                     s_axi_bvalid,
  input logic                     s_axi_bready,
  input axi_bridge_pkg::axil_aw_t m_axil_aw,
  input logic                     m_axil_awvalid,
  input logic                     m_axil_awready,
  input axi_bridge_pkg::axil_w_t  m_axil_w,
  input logic                     m_axil_wvalid,
  input logic                     m_axil_wready
);

  logic burst_open;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      burst_open <= 1'b0;
    end else if (s_axi_awvalid && s_axi_awready) begin
      burst_open <= 1'b1;           // From AW transfer to B transfer.
    end else if (s_axi_bvalid && s_axi_bready) begin
      burst_open <= 1'b0;
    end
  end

  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_axil_awvalid && !m_axil_awready |=> m_axil_awvalid && $stable(m_axil_aw))
    else $error("m_axil_aw dropped or changed before its transfer");

  w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_axil_wvalid && !m_axil_wready |=> m_axil_wvalid && $stable(m_axil_w))
    else $error("m_axil_w dropped or changed before its transfer");

  // Response stays up until taken.
  b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_b))
    else $error("s_axi_bvalid dropped before s_axi_bready");

  b_in_burst: assert property (@(posedge clk) disable iff (!rst_n)
    s_axi_bvalid |-> burst_open)
    else $error("s_axi_bvalid high outside an accepted burst");

  no_aw_in_b: assert property (@(posedge clk) disable iff (!rst_n)
    burst_open |-> !s_axi_awready)
    else $error("s_axi_awready high while a burst is open");

endmodule

bind axi_axil_wr_bridge axi_axil_wr_bridge_props u_props (
  .clk            (clk),
  .rst_n          (rst_n),
  .s_axi_awvalid  (s_axi_awvalid),
  .s_axi_awready  (s_axi_awready),
  .s_axi_b        (s_axi_b),
  .s_axi_bvalid   (s_axi_bvalid),
  .s_axi_bready   (s_axi_bready),
  .m_axil_aw      (m_axil_aw),
  .m_axil_awvalid (m_axil_awvalid),
  .m_axil_awready (m_axil_awready),
  .m_axil_w       (m_axil_w),
  .m_axil_wvalid  (m_axil_wvalid),
  .m_axil_wready  (m_axil_wready)
);

// ==== axi_axil_wr_bridge.sv ====
`timescale 1ns/1ns

module axi_axil_wr_bridge (
  input  logic                     clk,
  input  logic                     rst_n,

  input  axi_bridge_pkg::axi_aw_t  s_axi_aw,
  input  logic                     s_axi_awvalid,
  output logic                     s_axi_awready,
  input  axi_bridge_pkg::axi_w_t   s_axi_w,
  input  logic                     s_axi_wvalid,
  output logic                     s_axi_wready,
  output axi_bridge_pkg::axi_b_t   s_axi_b,
  output logic                     s_axi_bvalid,
  input  logic                     s_axi_bready,

  output axi_bridge_pkg::axil_aw_t m_axil_aw,
  output logic                     m_axil_awvalid,
  input  logic                     m_axil_awready,
  output axi_bridge_pkg::axil_w_t  m_axil_w,
  output logic                     m_axil_wvalid,
  input  logic                     m_axil_wready,
  input  logic [1:0]               m_axil_bresp,
  input  logic                     m_axil_bvalid,
  output logic                     m_axil_bready
);

  import axi_bridge_pkg::*;

  logic                      aw_load;
  logic                      beat_issue;
  logic                      beat_step;
  logic                      resp_clear;
  logic                      resp_take;
  logic                      last_beat;
  logic                      aw_busy;
  logic                      w_busy;
  logic [AXI_ADDR_WIDTH-1:0] beat_addr;
  axil_aw_t                  aw_beat;
  axil_w_t                   w_beat;

  assign aw_beat.addr = beat_addr;
  assign w_beat.data  = s_axi_w.data;
  assign w_beat.strb  = s_axi_w.strb;

  axi_wr_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .m_axil_bvalid (m_axil_bvalid),
    .m_axil_bready (m_axil_bready),
    .last_beat     (last_beat),
    .aw_busy       (aw_busy),
    .w_busy        (w_busy),
    .aw_load       (aw_load),
    .beat_issue    (beat_issue),
    .beat_step     (beat_step),
    .resp_clear    (resp_clear),
    .resp_take     (resp_take)
  );

  axi_wr_addr_gen u_addr_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .aw_load   (aw_load),
    .beat_step (beat_step),
    .s_axi_aw  (s_axi_aw),
    .beat_addr (beat_addr),
    .last_beat (last_beat)
  );

  axi_wr_hold #(.payload_t(axil_aw_t)) u_aw_hold (
    .clk         (clk),
    .rst_n       (rst_n),
    .load        (beat_issue),
    .payload_in  (aw_beat),
    .valid       (m_axil_awvalid),
    .ready       (m_axil_awready),
    .payload_out (m_axil_aw),
    .busy        (aw_busy)
  );

  axi_wr_hold #(.payload_t(axil_w_t)) u_w_hold (
    .clk         (clk),
    .rst_n       (rst_n),
    .load        (beat_issue),
    .payload_in  (w_beat),
    .valid       (m_axil_wvalid),
    .ready       (m_axil_wready),
    .payload_out (m_axil_w),
    .busy        (w_busy)
  );

  axi_wr_resp u_resp (
    .clk          (clk),
    .rst_n        (rst_n),
    .resp_clear   (resp_clear),
    .resp_take    (resp_take),
    .s_axi_aw     (s_axi_aw),
    .m_axil_bresp (m_axil_bresp),
    .s_axi_b      (s_axi_b)
  );

endmodule

// ==== axi_wr_ctrl.sv ====
`timescale 1ns/1ns

module axi_wr_ctrl (
  input  logic clk,
  input  logic rst_n,

  input  logic s_axi_awvalid,
  output logic s_axi_awready,
  input  logic s_axi_wvalid,
  output logic s_axi_wready,
  output logic s_axi_bvalid,
  input  logic s_axi_bready,

  input  logic m_axil_bvalid,
  output logic m_axil_bready,

  input  logic last_beat,
  input  logic aw_busy,
  input  logic w_busy,

  output logic aw_load,
  output logic beat_issue,
  output logic beat_step,
  output logic resp_clear,
  output logic resp_take
);

  typedef enum logic [1:0] {
    IDLE,
    BEAT,
    RESP,
    BDONE
  } state_t;

  state_t state;
  state_t state_next;

  logic holds_free;
  logic aw_xfer;
  logic w_xfer;
  logic lite_b_xfer;
  logic b_xfer;

  // Both AXI-Lite channels have drained.
  assign holds_free = !aw_busy && !w_busy;

  assign s_axi_awready = (state == IDLE);
  assign s_axi_wready  = (state == BEAT) && holds_free;
  assign m_axil_bready = (state == RESP) && holds_free;
  assign s_axi_bvalid  = (state == BDONE);

  assign aw_xfer     = s_axi_awvalid && s_axi_awready;
  assign w_xfer      = s_axi_wvalid && s_axi_wready;
  assign lite_b_xfer = m_axil_bvalid && m_axil_bready;
  assign b_xfer      = s_axi_bvalid && s_axi_bready;

  // Single-cycle strobes into the datapath.
  assign aw_load    = aw_xfer;
  assign resp_clear = aw_xfer;      // New burst, fresh merge.
  assign beat_issue = w_xfer;
  assign resp_take  = lite_b_xfer;
  assign beat_step  = lite_b_xfer && !last_beat;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (aw_xfer) begin
          state_next = BEAT;
        end
      end
      BEAT: begin
        if (w_xfer) begin
          state_next = RESP;
        end
      end
      RESP: begin
        // The beat count from len ends the burst.
        if (lite_b_xfer) begin
          state_next = last_beat ? BDONE : BEAT;
        end
      end
      BDONE: begin
        if (b_xfer) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

endmodule

// ==== axi_wr_resp.sv ====
`timescale 1ns/1ns

module axi_wr_resp (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    resp_clear,
  input  logic                    resp_take,
  input  axi_bridge_pkg::axi_aw_t s_axi_aw,
  input  logic [1:0]              m_axil_bresp,
  output axi_bridge_pkg::axi_b_t  s_axi_b
);

  import axi_bridge_pkg::*;

  logic [AXI_ID_WIDTH-1:0]   id;
  logic [AXI_USER_WIDTH-1:0] user;
  logic [1:0]                merged;
  logic [1:0]                incoming;

  // No exclusive access through AXI-Lite.
  assign incoming = (m_axil_bresp == RESP_EXOKAY) ? RESP_OKAY : m_axil_bresp;

  always_ff @(posedge clk) begin
    if (resp_clear) begin
      id   <= s_axi_aw.id;
      user <= s_axi_aw.user;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      merged <= RESP_OKAY;
    end else if (resp_clear) begin
      merged <= RESP_OKAY;
    end else if (resp_take && (incoming > merged)) begin
      merged <= incoming;           // Worst code wins.
    end
  end

  always_comb begin
    s_axi_b      = '0;
    s_axi_b.id   = id;
    s_axi_b.resp = merged;
    s_axi_b.user = user;
  end

endmodule

// ==== axi_wr_addr_gen.sv ====
`timescale 1ns/1ns

module axi_wr_addr_gen (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       aw_load,
  input  logic                                       beat_step,
  input  axi_bridge_pkg::axi_aw_t                    s_axi_aw,
  output logic [axi_bridge_pkg::AXI_ADDR_WIDTH-1:0] beat_addr,
  output logic                                       last_beat
);

  import axi_bridge_pkg::*;

  logic [AXI_ADDR_WIDTH-1:0] addr;
  logic [2:0]                size;
  logic [1:0]                burst;
  logic [7:0]                remaining;
  logic [AXI_ADDR_WIDTH-1:0] step;

  // Bytes per beat.
  assign step = AXI_ADDR_WIDTH'(1) << size;

  always_ff @(posedge clk) begin
    if (aw_load) begin
      addr  <= s_axi_aw.addr;
      size  <= s_axi_aw.size;
      burst <= s_axi_aw.burst;
    end else if (beat_step) begin
      if (burst != BURST_FIXED) begin
        addr <= addr + step;        // INCR, and WRAP as INCR.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      remaining <= 8'd0;
    end else if (aw_load) begin
      remaining <= s_axi_aw.len;
    end else if (beat_step) begin
      remaining <= remaining - 8'd1;
    end
  end

  assign beat_addr = addr;
  assign last_beat = (remaining == 8'd0);

endmodule

// ==== axi_wr_hold.sv ====
`timescale 1ns/1ns

module axi_wr_hold #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     load,
  input  payload_t payload_in,
  output logic     valid,
  input  logic     ready,
  output payload_t payload_out,
  output logic     busy
);

  payload_t payload;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid <= 1'b0;
    end else if (load) begin
      valid <= 1'b1;
    end else if (valid && ready) begin
      valid <= 1'b0;                // Drops on its own transfer.
    end
  end

  // Only loaded while idle, so stable under back-pressure.
  always_ff @(posedge clk) begin
    if (load) begin
      payload <= payload_in;
    end
  end

  assign payload_out = payload;
  assign busy        = valid;

endmodule

// ==== axi_bridge_pkg.sv ====
package axi_bridge_pkg;

  localparam int AXI_ADDR_WIDTH = 20;
  localparam int AXI_DATA_WIDTH = 16;
  localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;
  localparam int AXI_ID_WIDTH   = 4;
  localparam int AXI_USER_WIDTH = 2;

  // AXI response codes, ordered by severity.
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_EXOKAY = 2'b01;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  // WRAP is not decoded and behaves as INCR.
  localparam logic [1:0] BURST_FIXED = 2'b00;
  localparam logic [1:0] BURST_INCR  = 2'b01;

  // Full AXI write address channel.
  typedef struct packed {
    logic [AXI_ADDR_WIDTH-1:0] addr;
    logic [AXI_ID_WIDTH-1:0]   id;
    logic [7:0]                len;    // Beats minus one.
    logic [2:0]                size;   // Log2 of bytes per beat.
    logic [1:0]                burst;
    logic [AXI_USER_WIDTH-1:0] user;
  } axi_aw_t;

  // Full AXI write data channel.
  typedef struct packed {
    logic [AXI_DATA_WIDTH-1:0] data;
    logic [AXI_STRB_WIDTH-1:0] strb;
    logic                      last;
  } axi_w_t;

  // Full AXI write response channel.
  typedef struct packed {
    logic [AXI_ID_WIDTH-1:0]   id;
    logic [1:0]                resp;
    logic [AXI_USER_WIDTH-1:0] user;
  } axi_b_t;

  // AXI-Lite write address channel.
  typedef struct packed {
    logic [AXI_ADDR_WIDTH-1:0] addr;
  } axil_aw_t;

  // AXI-Lite write data channel.
  typedef struct packed {
    logic [AXI_DATA_WIDTH-1:0] data;
    logic [AXI_STRB_WIDTH-1:0] strb;
  } axil_w_t;

endpackage
